/* rv32i_execute.f */
+incdir+source
source/rv32i_types.sv
source/issue_queue.sv
source/alu_unit.sv
source/writeback_stage.sv
source/rv32i_execute.sv
dv/exec_checker.sv
dv/tb_rv32i_execute.sv

/* dv/tb_rv32i_execute.sv */
`timescale 1ns/1ns

module tb_rv32i_execute
import rv32i_types::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_ROWS     = 24;
    localparam int TIMEOUT    = N_ROWS * 10 * CLK_PERIOD + 5 * CLK_PERIOD;

    typedef struct {
        alu_ops_t    op;
        alu_m1_sel_t m1;
        alu_m2_sel_t m2;
        word_t       rs1;
        word_t       rs2;
        word_t       imm;
        word_t       pc;
    } row_t;

    row_t        rows [N_ROWS];
    int          n_loaded;
    int          rows_sent;
    int          seed;
    bit          accepted;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    word_t       in_pc;
    word_t       in_inst;
    word_t       in_rs1_data;
    word_t       in_rs2_data;
    word_t       in_imm_sext;
    alu_m1_sel_t in_alu_m1_sel;
    alu_m2_sel_t in_alu_m2_sel;
    alu_ops_t    in_aluop;
    reg_addr_t   in_rd_addr;
    rob_idx_t    in_rd_rob_idx;
    logic        in_regf_we;
    logic        in_ready;
    logic        wb_valid;
    word_t       wb_pc;
    word_t       wb_inst;
    reg_addr_t   wb_rd_addr;
    rob_idx_t    wb_rd_rob_idx;
    word_t       wb_rd_data;
    logic        wb_regf_we;
    logic        wb_ready;
    int          n_pass;
    int          n_fail;
    int          n_retired;
    int          n_pending;
    int          n_stalls;

    rv32i_execute rv32i_execute_i (.*);

    exec_checker exec_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // pc follows the row index
    task automatic add_row(input alu_ops_t op, input alu_m1_sel_t m1, input alu_m2_sel_t m2,
                           input word_t rs1, input word_t rs2, input word_t imm);
        rows[n_loaded] = '{op, m1, m2, rs1, rs2, imm, 32'h0000_1000 + (word_t'(n_loaded) << 2)};
        n_loaded++;
    endtask

    task automatic load_table();
        add_row(alu_op_add,  rs1_out, rs2_out,  32'h0000_1234, 32'h0000_4321, 32'h0);
        add_row(alu_op_add,  rs1_out, rs2_out,  32'h7fff_ffff, 32'h0000_0001, 32'h0);
        add_row(alu_op_sub,  rs1_out, rs2_out,  32'h0000_0010, 32'h0000_0020, 32'h0);  // wraps
        add_row(alu_op_sub,  rs1_out, rs2_out,  32'h8000_0000, 32'h0000_0001, 32'h0);
        add_row(alu_op_xor,  rs1_out, rs2_out,  32'hf0f0_a5a5, 32'h0ff0_5a5a, 32'h0);
        add_row(alu_op_or,   rs1_out, rs2_out,  32'h1200_0034, 32'h0034_5600, 32'h0);
        add_row(alu_op_and,  rs1_out, rs2_out,  32'hdead_beef, 32'h0f0f_ff00, 32'h0);
        // shift amounts above 31
        add_row(alu_op_sll,  rs1_out, rs2_out,  32'h0000_0001, 32'h0000_0023, 32'h0);
        add_row(alu_op_srl,  rs1_out, rs2_out,  32'h8000_0000, 32'h0000_003f, 32'h0);
        add_row(alu_op_sra,  rs1_out, rs2_out,  32'h8000_0010, 32'h0000_0024, 32'h0);
        add_row(alu_op_sra,  rs1_out, rs2_out,  32'hf000_0000, 32'hffff_ffe8, 32'h0);
        add_row(alu_op_sra,  rs1_out, rs2_out,  32'h4000_0000, 32'h0000_0041, 32'h0);
        add_row(alu_op_srl,  rs1_out, rs2_out,  32'hffff_ffff, 32'h0000_0020, 32'h0);
        // signed and unsigned order disagree
        add_row(alu_op_slt,  rs1_out, rs2_out,  32'hffff_ffff, 32'h0000_0001, 32'h0);
        add_row(alu_op_sltu, rs1_out, rs2_out,  32'hffff_ffff, 32'h0000_0001, 32'h0);
        add_row(alu_op_slt,  rs1_out, rs2_out,  32'h0000_0001, 32'h8000_0000, 32'h0);
        add_row(alu_op_sltu, rs1_out, rs2_out,  32'h0000_0001, 32'h8000_0000, 32'h0);
        add_row(alu_op_slt,  rs1_out, rs2_out,  32'h0000_0005, 32'h0000_0005, 32'h0);
        // operand selection
        add_row(alu_op_add,  pc_out,  four_out, 32'h0000_2000, 32'h0, 32'h0);  // link
        add_row(alu_op_add,  rs1_out, imm_out,  32'h0000_0100, 32'h0, 32'hffff_fff0);
        add_row(alu_op_add,  pc_out,  imm_out,  32'h0000_3000, 32'h0, 32'h0000_0800);
        add_row(alu_op_add,  no_out,  imm_out,  32'h0000_5555, 32'h0, 32'h1234_5000);
        add_row(alu_op_sll,  rs1_out, imm_out,  32'h0000_0003, 32'h0, 32'h0000_0004);
        add_row(alu_op_xor,  rs1_out, imm_out,  32'hffff_ffff, 32'h0, 32'hffff_f800);
    endtask

    task automatic drive_row(input int i);
        in_valid      = 1'b1;
        in_aluop      = rows[i].op;
        in_alu_m1_sel = rows[i].m1;
        in_alu_m2_sel = rows[i].m2;
        in_rs1_data   = rows[i].rs1;
        in_rs2_data   = rows[i].rs2;
        in_imm_sext   = rows[i].imm;
        in_pc         = rows[i].pc;
        in_inst       = 32'h0000_0033 | (word_t'(i) << 7);
        in_rd_addr    = reg_addr_t'(i + 1);
        in_rd_rob_idx = rob_idx_t'(i);
        in_regf_we    = (i % 4) != 3;  // every fourth row writes no register
    endtask

    // ====================
    // stimulus and verdict
    // ====================
    initial begin
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_rs1_data   = '0;
        in_rs2_data   = '0;
        in_imm_sext   = '0;
        in_alu_m1_sel = rs1_out;
        in_alu_m2_sel = rs2_out;
        in_aluop      = alu_op_add;
        in_rd_addr    = '0;
        in_rd_rob_idx = '0;
        in_regf_we    = 1'b0;
        wb_ready      = 1'b1;
        seed          = 32'hc0a7;
        rows_sent     = 0;
        n_loaded      = 0;
        load_table();
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < N_ROWS; i++) begin
            drive_row(i);
            do begin
                @(negedge clk);
                accepted = in_ready;  // transfer happens on the coming edge
                @(posedge clk);
                #2;
            end while (!accepted);
            rows_sent++;
        end
        in_valid = 1'b0;
        wait (n_retired == N_ROWS);
        repeat (4) @(posedge clk);  // catch stray results
        $display("rows %0d, passed %0d, failed %0d, pending %0d, stalls %0d",
                 N_ROWS, n_pass, n_fail, n_pending, n_stalls);
        if (n_stalls == 0) $display("the issue queue never filled under back-pressure");
        if (n_fail == 0 && n_pending == 0 && n_stalls > 0 && n_pass == N_ROWS) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // cdb back-pressure, full speed for the first third
    initial begin
        bit full_speed;
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            full_speed = (rows_sent < N_ROWS / 3);  // row count sampled at the edge
            #2;
            if (full_speed) wb_ready = 1'b1;
            else wb_ready = ($random(seed) & 1) != 0;
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout after %0d ns with %0d of %0d results retired",
                 TIMEOUT, n_retired, N_ROWS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* dv/exec_checker.sv */
`timescale 1ns/1ns

module exec_checker
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic        in_ready,
    input  word_t       in_pc,
    input  word_t       in_inst,
    input  word_t       in_rs1_data,
    input  word_t       in_rs2_data,
    input  word_t       in_imm_sext,
    input  alu_m1_sel_t in_alu_m1_sel,
    input  alu_m2_sel_t in_alu_m2_sel,
    input  alu_ops_t    in_aluop,
    input  reg_addr_t   in_rd_addr,
    input  rob_idx_t    in_rd_rob_idx,
    input  logic        in_regf_we,
    input  logic        wb_valid,
    input  word_t       wb_pc,
    input  word_t       wb_inst,
    input  reg_addr_t   wb_rd_addr,
    input  rob_idx_t    wb_rd_rob_idx,
    input  word_t       wb_rd_data,
    input  logic        wb_regf_we,
    input  logic        wb_ready,
    output int          n_pass,
    output int          n_fail,
    output int          n_retired,
    output int          n_pending,
    output int          n_stalls
);

    to_writeback_t exp_q[$];  // predicted results, oldest first

    // reference model of the alu rules
    function automatic word_t predict(alu_ops_t op, alu_m1_sel_t m1, alu_m2_sel_t m2,
                                      word_t rs1, word_t rs2, word_t imm, word_t pc);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        a  = (m1 == rs1_out) ? rs1 : ((m1 == pc_out) ? pc : 32'h0);
        b  = (m2 == rs2_out) ? rs2 : ((m2 == imm_out) ? imm : ((m2 == four_out) ? 32'h4 : 32'h0));
        sh = b[4:0];  // shifts only see five bits
        case (op)
            alu_op_add:  return a + b;
            alu_op_sub:  return a + ~b + 32'h1;
            alu_op_sll:  return a << sh;
            alu_op_srl:  return a >> sh;
            alu_op_sra:  return a[31] ? ~((~a) >> sh) : (a >> sh);
            alu_op_xor:  return a ^ b;
            alu_op_or:   return a | b;
            alu_op_and:  return a & b;
            // differing signs decide slt by the sign of a
            alu_op_slt:  return (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
            alu_op_sltu: return {31'h0, a < b};
            default:     return 32'h0;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v, inout bit ok);
        if (got_v !== exp_v) begin
            $display("** Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp_v, got_v);
            ok = 1'b0;
        end
    endtask

    initial begin
        n_pass    = 0;
        n_fail    = 0;
        n_retired = 0;
        n_pending = 0;
        n_stalls  = 0;
    end

    // ====================
    // reset state
    // ====================
    initial begin
        @(posedge arst_n);
        @(negedge clk);
        if (wb_valid !== 1'b0) begin
            $display("** Error at %0t ns: wb_valid expected 0, got %b", $time, wb_valid);
            n_fail++;
        end
        if (in_ready !== 1'b1) begin
            $display("** Error at %0t ns: in_ready expected 1, got %b", $time, in_ready);
            n_fail++;
        end
        $display("reset state checked");
    end

    // ====================
    // scoreboard
    // ====================
    // sampled mid-cycle, where handshakes are settled
    always @(negedge clk) begin
        to_writeback_t exp_rec;
        bit            ok;
        if (arst_n) begin
            if (in_valid && !in_ready) n_stalls++;  // row held off by a full queue
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t ns: a result retired while no operation was pending", $time);
                    n_fail++;
                end else begin
                    exp_rec = exp_q.pop_front();
                    ok      = 1'b1;
                    check_field("wb_pc", exp_rec.pc, wb_pc, ok);
                    check_field("wb_inst", exp_rec.inst, wb_inst, ok);
                    check_field("wb_rd_addr", 32'(exp_rec.rd_addr), 32'(wb_rd_addr), ok);
                    check_field("wb_rd_rob_idx", 32'(exp_rec.rd_rob_idx), 32'(wb_rd_rob_idx), ok);
                    check_field("wb_rd_data", exp_rec.rd_data, wb_rd_data, ok);
                    check_field("wb_regf_we", 32'(exp_rec.regf_we), 32'(wb_regf_we), ok);
                    if (ok) n_pass++;
                    else n_fail++;
                    $display("row %0d rob %0d: %s", n_retired, wb_rd_rob_idx,
                             ok ? "ok" : "mismatch");
                    n_retired++;
                end
            end
            if (in_valid && in_ready) begin
                exp_rec            = '0;
                exp_rec.valid      = 1'b1;
                exp_rec.pc         = in_pc;
                exp_rec.inst       = in_inst;
                exp_rec.rd_addr    = in_rd_addr;
                exp_rec.rd_rob_idx = in_rd_rob_idx;
                exp_rec.rd_data    = predict(in_aluop, in_alu_m1_sel, in_alu_m2_sel,
                                             in_rs1_data, in_rs2_data, in_imm_sext, in_pc);
                exp_rec.regf_we    = in_regf_we;
                exp_q.push_back(exp_rec);
            end
            n_pending = exp_q.size();
        end
    end

endmodule

/* source/rv32i_execute.sv */
`timescale 1ns/1ns

module rv32i_execute
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // from reservation station
    input  logic        in_valid,
    input  word_t       in_pc,
    input  word_t       in_inst,
    input  word_t       in_rs1_data,
    input  word_t       in_rs2_data,
    input  word_t       in_imm_sext,
    input  alu_m1_sel_t in_alu_m1_sel,
    input  alu_m2_sel_t in_alu_m2_sel,
    input  alu_ops_t    in_aluop,
    input  reg_addr_t   in_rd_addr,
    input  rob_idx_t    in_rd_rob_idx,
    input  logic        in_regf_we,
    output logic        in_ready,
    // toward common data bus
    output logic        wb_valid,
    output word_t       wb_pc,
    output word_t       wb_inst,
    output reg_addr_t   wb_rd_addr,
    output rob_idx_t    wb_rd_rob_idx,
    output word_t       wb_rd_data,
    output logic        wb_regf_we,
    input  logic        wb_ready
);

    reservation_station_t in_entry;
    reservation_station_t head_entry;
    to_writeback_t        alu_result;
    to_writeback_t        wb_result;
    logic                 alu_ready;
    logic                 head_ready;

    assign in_entry = '{
        valid:      in_valid,
        pc:         in_pc,
        inst:       in_inst,
        rs1_data:   in_rs1_data,
        rs2_data:   in_rs2_data,
        imm_sext:   in_imm_sext,
        alu_m1_sel: in_alu_m1_sel,
        alu_m2_sel: in_alu_m2_sel,
        aluop:      in_aluop,
        rd_addr:    in_rd_addr,
        rd_rob_idx: in_rd_rob_idx,
        regf_we:    in_regf_we
    };

    // ====================
    // stage chain
    // ====================
    issue_queue issue_queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_entry   (in_entry),
        .in_ready   (in_ready),
        .head_entry (head_entry),
        .head_ready (head_ready)
    );

    alu_unit alu_unit_i (
        .next_execute   (head_entry),
        .alu_ready_out  (head_ready),
        .execute_output (alu_result),
        .wb_ready_in    (alu_ready)
    );

    writeback_stage writeback_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .alu_result (alu_result),
        .alu_ready  (alu_ready),
        .wb_result  (wb_result),
        .wb_ready   (wb_ready)
    );

    // flat cdb outputs
    assign wb_valid      = wb_result.valid;
    assign wb_pc         = wb_result.pc;
    assign wb_inst       = wb_result.inst;
    assign wb_rd_addr    = wb_result.rd_addr;
    assign wb_rd_rob_idx = wb_result.rd_rob_idx;
    assign wb_rd_data    = wb_result.rd_data;
    assign wb_regf_we    = wb_result.regf_we;

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage
import rv32i_types::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  to_writeback_t alu_result,
    output logic          alu_ready,
    output to_writeback_t wb_result,
    input  logic          wb_ready
);

    logic          wb_valid_q;
    to_writeback_t wb_data_q;   // payload, valid bit unused

    // empty, or the held result retires now
    assign alu_ready = !wb_valid_q || wb_ready;

    // ====================
    // output register
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid_q <= 1'b0;
        end else if (alu_ready) begin
            wb_valid_q <= alu_result.valid;  // drops to 0 on retire without refill
        end
    end

    always_ff @(posedge clk) begin
        if (alu_ready && alu_result.valid) begin
            wb_data_q <= alu_result;
        end
    end

    always_comb begin
        wb_result       = wb_data_q;
        wb_result.valid = wb_valid_q;
    end

    // ====================
    // checks
    // ====================
    // cdb stalls must see a frozen record
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_result.valid && !wb_ready) |=> $stable(wb_result)
    ) else $error("writeback record changed under back-pressure");

endmodule

/* source/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit
import rv32i_types::*;
(
    input  reservation_station_t next_execute,
    output logic                 alu_ready_out,
    output to_writeback_t        execute_output,
    input  logic                 wb_ready_in
);

    word_t a;
    word_t b;
    word_t aluout;

    // ready comes straight from writeback
    assign alu_ready_out = wb_ready_in;

    // ====================
    // operand select
    // ====================
    always_comb begin
        case (next_execute.alu_m1_sel)
            rs1_out: a = next_execute.rs1_data;
            pc_out:  a = next_execute.pc;
            no_out:  a = '0;
            default: a = '0;
        endcase

        case (next_execute.alu_m2_sel)
            rs2_out:  b = next_execute.rs2_data;
            imm_out:  b = next_execute.imm_sext;
            four_out: b = word_t'(4);  // link address
            default:  b = '0;
        endcase
    end

    // ====================
    // operation
    // ====================
    always_comb begin
        case (next_execute.aluop)
            alu_op_add:  aluout = a + b;
            alu_op_sub:  aluout = a - b;
            alu_op_sll:  aluout = a << b[4:0];
            alu_op_srl:  aluout = a >> b[4:0];
            alu_op_sra:  aluout = word_t'($signed(a) >>> b[4:0]);  // sign fill
            alu_op_xor:  aluout = a ^ b;
            alu_op_or:   aluout = a | b;
            alu_op_and:  aluout = a & b;
            alu_op_slt:  aluout = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            alu_op_sltu: aluout = (a < b) ? word_t'(1) : word_t'(0);
            default:     aluout = '0;
        endcase
    end

    // writeback record, zero when idle
    always_comb begin
        execute_output = '0;

        if (next_execute.valid) begin
            execute_output.valid      = 1'b1;
            execute_output.pc         = next_execute.pc;
            execute_output.inst       = next_execute.inst;
            execute_output.rd_addr    = next_execute.rd_addr;
            execute_output.rd_rob_idx = next_execute.rd_rob_idx;
            execute_output.rd_data    = aluout;
            execute_output.regf_we    = next_execute.regf_we;
        end
    end

endmodule

/* source/issue_queue.sv */
`timescale 1ns/1ns
`include "rv32i_cfg.svh"

module issue_queue
import rv32i_types::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  reservation_station_t in_entry,
    output logic                 in_ready,
    output reservation_station_t head_entry,
    input  logic                 head_ready
);

    typedef logic [$clog2(`RV_IQ_DEPTH)-1:0] iq_ptr_t;
    typedef logic [$clog2(`RV_IQ_DEPTH+1)-1:0] iq_cnt_t;

    reservation_station_t mem [`RV_IQ_DEPTH];

    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;
    iq_cnt_t count;
    logic    push;
    logic    pop;

    // ====================
    // handshakes
    // ====================
    assign in_ready = (count != iq_cnt_t'(`RV_IQ_DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = head_entry.valid && head_ready;

    always_comb begin
        head_entry       = mem[rd_ptr];
        head_entry.valid = (count != '0);  // stored valid bit is ignored
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    // ====================
    // pointers and occupancy
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap at the last slot
                if (wr_ptr == iq_ptr_t'(`RV_IQ_DEPTH-1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == iq_ptr_t'(`RV_IQ_DEPTH-1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    // ====================
    // checks
    // ====================
    // a push onto the head slot only happens into an empty queue
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (push && (wr_ptr == rd_ptr)) |-> (count == '0)
    ) else $error("issue queue written while full");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= iq_cnt_t'(`RV_IQ_DEPTH)
    ) else $error("issue queue count above depth");

endmodule

/* source/rv32i_types.sv */
`include "rv32i_cfg.svh"

package rv32i_types;

    // ====================
    // plain vectors
    // ====================
    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [`RV_ROB_IW-1:0] rob_idx_t;

    // operand a source
    typedef enum logic [1:0] {
        rs1_out = 2'b00,
        pc_out  = 2'b01,
        no_out  = 2'b10
    } alu_m1_sel_t;

    // operand b source
    typedef enum logic [1:0] {
        rs2_out  = 2'b00,
        imm_out  = 2'b01,
        four_out = 2'b10
    } alu_m2_sel_t;

    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sll  = 4'd1,
        alu_op_sra  = 4'd2,
        alu_op_sub  = 4'd3,
        alu_op_xor  = 4'd4,
        alu_op_srl  = 4'd5,
        alu_op_or   = 4'd6,
        alu_op_and  = 4'd7,
        alu_op_slt  = 4'd8,
        alu_op_sltu = 4'd9
    } alu_ops_t;

    // ====================
    // stage records
    // ====================
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       inst;
        word_t       rs1_data;
        word_t       rs2_data;
        word_t       imm_sext;
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        alu_ops_t    aluop;
        reg_addr_t   rd_addr;
        rob_idx_t    rd_rob_idx;
        logic        regf_we;
    } reservation_station_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        reg_addr_t rd_addr;
        rob_idx_t  rd_rob_idx;
        word_t     rd_data;
        logic      regf_we;
    } to_writeback_t;

endpackage

/* source/rv32i_cfg.svh */
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// ====================
// datapath widths
// ====================
`define RV_XLEN      32  // data, pc and instruction word
`define RV_REG_AW    5   // architectural register number
`define RV_ROB_IW    4   // reorder buffer slot index

// ====================
// execute path sizing
// ====================
`define RV_IQ_DEPTH  4   // issue queue entries

`endif
